//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := tb_platform
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Simulation PASSED

# every source named in the file list, so a change to any of them rebuilds the binary
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the run passes only when the pass message shows up in the simulator output
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
src/bus_pkg.sv
src/plat_pkg.sv
src/debounce.sv
src/bus_ctrl.sv
src/ram_block.sv
src/pio_port.sv
src/interval_timer.sv
src/platform_top.sv
test/clk_gen.sv
test/tb_platform.sv

//--- src/bus_ctrl.sv
`timescale 1ns/1ps

module bus_ctrl
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic [bus_pkg::ADDR_W-1:0]    addr,
	input  logic [bus_pkg::DATA_W-1:0]    data_wr,
	input  logic [bus_pkg::BE_W-1:0]      data_be,
	input  logic                          write,
	input  logic                          start,
	output logic [bus_pkg::DATA_W-1:0]    data_rd,
	output logic                          ready,
	output logic                          ram_sel,
	output logic                          pio_sel,
	output logic                          tmr_sel,
	output logic [bus_pkg::OFFSET_W-1:0]  offset,
	output logic [bus_pkg::DATA_W-1:0]    wdata,
	output logic [bus_pkg::BE_W-1:0]      be,
	output logic                          wr,
	input  logic [bus_pkg::DATA_W-1:0]    ram_rdata,
	input  logic [bus_pkg::DATA_W-1:0]    pio_rdata,
	input  logic [bus_pkg::DATA_W-1:0]    tmr_rdata
);

	typedef enum logic [1:0] {
		IDLE,
		SELECT,
		WAIT,
		DONE
	} state_t;

	state_t state;
	logic [bus_pkg::REGION_W-1:0] region;

	// one select for one cycle, and none at all for the unmapped region.
	assign ram_sel = (state == SELECT) && (region == bus_pkg::REGION_RAM);
	assign pio_sel = (state == SELECT) && (region == bus_pkg::REGION_PIO);
	assign tmr_sel = (state == SELECT) && (region == bus_pkg::REGION_TIMER);

	assign ready = state == DONE;

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else begin
			unique case (state)
				IDLE:   if (start) state <= SELECT; // later starts are dropped.
				SELECT: state <= WAIT;
				WAIT:   state <= DONE;
				DONE:   state <= IDLE;
			endcase
		end
	end

	// the core holds its signals until ready, but a private copy keeps targets stable.
	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			region <= addr[bus_pkg::ADDR_W-1 -: bus_pkg::REGION_W];
			offset <= addr[bus_pkg::OFFSET_W-1:0];
			wdata <= data_wr;
			be <= data_be;
			wr <= write;
		end
	end

	always_ff @(posedge clk) begin
		if (state == WAIT) begin
			unique case (region)
				bus_pkg::REGION_RAM:   data_rd <= ram_rdata;
				bus_pkg::REGION_PIO:   data_rd <= pio_rdata;
				bus_pkg::REGION_TIMER: data_rd <= tmr_rdata;
				bus_pkg::REGION_NONE:  data_rd <= bus_pkg::UNMAPPED_RD;
			endcase
		end
	end

endmodule

//--- src/bus_pkg.sv
package bus_pkg;

	// core bus widths, counted in words and bytes.
	localparam int ADDR_W = 30;
	localparam int DATA_W = 32;
	localparam int BE_W   = 4;

	// the top two word address bits select the target.
	localparam int REGION_W = 2;

	localparam logic [REGION_W-1:0] REGION_RAM   = 2'b00;
	localparam logic [REGION_W-1:0] REGION_PIO   = 2'b01;
	localparam logic [REGION_W-1:0] REGION_TIMER = 2'b10;
	localparam logic [REGION_W-1:0] REGION_NONE  = 2'b11;

	// low word address bits handed to every target.
	localparam int OFFSET_W = 8;

	// returned for any read that hits the unmapped region.
	localparam logic [DATA_W-1:0] UNMAPPED_RD = 32'hbad0_cafe;

endpackage

//--- src/debounce.sv
`timescale 1ns/1ps

module debounce
#(
	parameter type payload_t = logic
)
(
	input  logic     clk,
	input  logic     rst,
	input  payload_t dirty,
	output payload_t clean
);

	payload_t sync_a, sync_b, candidate;
	logic [plat_pkg::DEBOUNCE_CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (rst) begin
			sync_a <= '0;
			sync_b <= '0;
			candidate <= '0;
			count <= '0;
			clean <= '0;
		end else begin
			sync_a <= dirty;
			sync_b <= sync_a; // two flops against metastability.

			if (sync_b != candidate) begin
				candidate <= sync_b; // any movement starts the wait over.
				count <= '0;
			end else if (count == plat_pkg::DEBOUNCE_LAST)
				clean <= candidate;
			else
				count <= count + 1'b1;
		end
	end

endmodule

//--- src/interval_timer.sv
`timescale 1ns/1ps

module interval_timer
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          sel,
	input  logic                          wr,
	input  logic [bus_pkg::OFFSET_W-1:0]  offset,
	input  logic [bus_pkg::DATA_W-1:0]    wdata,
	output logic [bus_pkg::DATA_W-1:0]    rdata,
	output logic                          irq
);

	logic [bus_pkg::DATA_W-1:0] reload, count;
	logic [1:0] ctrl; // bit 0 runs the counter, bit 1 lets status reach irq.
	logic status, ctrl_wr, status_clr;

	assign ctrl_wr = sel && wr && offset == plat_pkg::TMR_CTRL;
	assign status_clr = sel && wr && offset == plat_pkg::TMR_STATUS && wdata[0];

	assign irq = status && ctrl[1];

	always_ff @(posedge clk) begin
		if (rst) begin
			reload <= '0;
			count <= '0;
			ctrl <= '0;
			status <= 1'b0;
		end else begin
			if (sel && wr && offset == plat_pkg::TMR_RELOAD)
				reload <= wdata;

			if (status_clr)
				status <= 1'b0;

			if (ctrl_wr) begin
				ctrl <= wdata[1:0];
				count <= reload; // a fresh start on every enabling write.
			end else if (ctrl[0]) begin
				if (count == '0) begin
					status <= 1'b1; // expiry beats a clear in the same cycle.
					count <= reload;
				end else
					count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sel) begin
			rdata <= '0;
			case (offset)
				plat_pkg::TMR_RELOAD: rdata <= reload;
				plat_pkg::TMR_CTRL:   rdata[1:0] <= ctrl;
				plat_pkg::TMR_STATUS: rdata[0] <= status;
				default: ;
			endcase
		end
	end

endmodule

//--- src/pio_port.sv
`timescale 1ns/1ps

module pio_port
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          sel,
	input  logic                          wr,
	input  logic [bus_pkg::OFFSET_W-1:0]  offset,
	input  logic [bus_pkg::DATA_W-1:0]    wdata,
	output logic [bus_pkg::DATA_W-1:0]    rdata,
	input  logic [plat_pkg::BTN_W-1:0]    btns,
	output logic [plat_pkg::LED_W-1:0]    leds,
	output logic                          irq
);

	logic [plat_pkg::BTN_W-1:0] btn_prev, edges, edge_clr;

	assign irq = |edges;

	// writing a one to an edge bit acknowledges it.
	assign edge_clr = (sel && wr && offset == plat_pkg::PIO_EDGE) ?
	                  wdata[plat_pkg::BTN_W-1:0] : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			leds <= '0;
			btn_prev <= '0;
			edges <= '0;
		end else begin
			btn_prev <= btns;
			edges <= (edges & ~edge_clr) | (btns & ~btn_prev); // new edges win.

			if (sel && wr && offset == plat_pkg::PIO_LEDS)
				leds <= wdata[plat_pkg::LED_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (sel) begin
			rdata <= '0;
			case (offset)
				plat_pkg::PIO_LEDS: rdata[plat_pkg::LED_W-1:0] <= leds;
				plat_pkg::PIO_BTNS: rdata[plat_pkg::BTN_W-1:0] <= btns;
				plat_pkg::PIO_EDGE: rdata[plat_pkg::BTN_W-1:0] <= edges;
				default: ;
			endcase
		end
	end

endmodule

//--- src/plat_pkg.sv
package plat_pkg;

	localparam int RAM_WORDS  = 256;
	localparam int RAM_ADDR_W = $clog2(RAM_WORDS);

	localparam int LED_W = 8;
	localparam int BTN_W = 4;

	// stable cycles required before a debounced output moves.
	localparam int DEBOUNCE_CYCLES = 16;
	localparam int DEBOUNCE_CNT_W  = $clog2(DEBOUNCE_CYCLES);
	localparam logic [DEBOUNCE_CNT_W-1:0] DEBOUNCE_LAST = DEBOUNCE_CNT_W'(DEBOUNCE_CYCLES - 1);

	localparam logic [bus_pkg::OFFSET_W-1:0] PIO_LEDS = 8'd0;
	localparam logic [bus_pkg::OFFSET_W-1:0] PIO_BTNS = 8'd1;
	localparam logic [bus_pkg::OFFSET_W-1:0] PIO_EDGE = 8'd2;

	localparam logic [bus_pkg::OFFSET_W-1:0] TMR_RELOAD = 8'd0;
	localparam logic [bus_pkg::OFFSET_W-1:0] TMR_CTRL   = 8'd1;
	localparam logic [bus_pkg::OFFSET_W-1:0] TMR_STATUS = 8'd2;

endpackage

//--- src/platform_top.sv
`timescale 1ns/1ps

module platform_top
(
	input  logic                          clk_clk,
	input  logic                          rst,
	input  logic                          halt,
	input  logic [plat_pkg::BTN_W-1:0]    btns,
	input  logic [bus_pkg::ADDR_W-1:0]    addr,
	input  logic [bus_pkg::DATA_W-1:0]    data_wr,
	input  logic [bus_pkg::BE_W-1:0]      data_be,
	input  logic                          write,
	input  logic                          start,
	output logic [bus_pkg::DATA_W-1:0]    data_rd,
	output logic                          ready,
	output logic                          irq,
	output logic                          cpu_halt,
	output logic [plat_pkg::LED_W-1:0]    pio_leds
);

	logic [plat_pkg::BTN_W-1:0] btns_clean;
	logic [bus_pkg::OFFSET_W-1:0] offset;
	logic [bus_pkg::DATA_W-1:0] wdata, ram_rdata, pio_rdata, tmr_rdata;
	logic [bus_pkg::BE_W-1:0] be;
	logic ram_sel, pio_sel, tmr_sel, wr, pio_irq, tmr_irq;

	assign irq = pio_irq | tmr_irq;

	debounce #(.payload_t(logic)) halt_debounce
	(
		.clk(clk_clk),
		.rst(rst),
		.dirty(halt),
		.clean(cpu_halt)
	);

	debounce #(.payload_t(logic [plat_pkg::BTN_W-1:0])) btn_debounce
	(
		.clk(clk_clk),
		.rst(rst),
		.dirty(btns),
		.clean(btns_clean)
	);

	bus_ctrl ctrl
	(
		.clk(clk_clk),
		.rst(rst),
		.addr(addr),
		.data_wr(data_wr),
		.data_be(data_be),
		.write(write),
		.start(start),
		.data_rd(data_rd),
		.ready(ready),
		.ram_sel(ram_sel),
		.pio_sel(pio_sel),
		.tmr_sel(tmr_sel),
		.offset(offset),
		.wdata(wdata),
		.be(be),
		.wr(wr),
		.ram_rdata(ram_rdata),
		.pio_rdata(pio_rdata),
		.tmr_rdata(tmr_rdata)
	);

	ram_block ram
	(
		.clk(clk_clk),
		.sel(ram_sel),
		.wr(wr),
		.offset(offset),
		.wdata(wdata),
		.be(be),
		.rdata(ram_rdata)
	);

	pio_port pio
	(
		.clk(clk_clk),
		.rst(rst),
		.sel(pio_sel),
		.wr(wr),
		.offset(offset),
		.wdata(wdata),
		.rdata(pio_rdata),
		.btns(btns_clean),
		.leds(pio_leds),
		.irq(pio_irq)
	);

	interval_timer timer
	(
		.clk(clk_clk),
		.rst(rst),
		.sel(tmr_sel),
		.wr(wr),
		.offset(offset),
		.wdata(wdata),
		.rdata(tmr_rdata),
		.irq(tmr_irq)
	);

endmodule

//--- src/ram_block.sv
`timescale 1ns/1ps

module ram_block
(
	input  logic                          clk,
	input  logic                          sel,
	input  logic                          wr,
	input  logic [bus_pkg::OFFSET_W-1:0]  offset,
	input  logic [bus_pkg::DATA_W-1:0]    wdata,
	input  logic [bus_pkg::BE_W-1:0]      be,
	output logic [bus_pkg::DATA_W-1:0]    rdata
);

	logic [bus_pkg::DATA_W-1:0] mem[plat_pkg::RAM_WORDS];
	logic [plat_pkg::RAM_ADDR_W-1:0] word;

	assign word = offset[plat_pkg::RAM_ADDR_W-1:0]; // wraps at the RAM depth.

	always_ff @(posedge clk) begin
		if (sel) begin
			if (wr) begin
				for (int i = 0; i < bus_pkg::BE_W; i++) begin
					if (be[i])
						mem[word][8*i +: 8] <= wdata[8*i +: 8];
				end
			end

			// a read returns the word as it stood before this cycle.
			rdata <= mem[word];
		end
	end

endmodule

//--- test/clk_gen.sv
`timescale 1ns/1ps

module clk_gen
#(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 4
)
(
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst = 1'b0; // released just after an edge, like every other input.
	end

endmodule

//--- test/tb_platform.sv
`timescale 1ns/1ps

module tb_platform;

	localparam int ACCESS_CYCLES = 3; // decode, target register, data placement.
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int SETTLE = plat_pkg::DEBOUNCE_CYCLES + 6; // synchronizer and edge detect too.
	localparam int RELOAD = 30;

	localparam logic [1:0] RAM = bus_pkg::REGION_RAM;
	localparam logic [1:0] PIO = bus_pkg::REGION_PIO;
	localparam logic [1:0] TMR = bus_pkg::REGION_TIMER;
	localparam logic [1:0] NONE = bus_pkg::REGION_NONE;

	logic clk, rst, halt, write, start, ready, irq, cpu_halt;
	logic [plat_pkg::BTN_W-1:0] btns;
	logic [bus_pkg::ADDR_W-1:0] addr;
	logic [bus_pkg::DATA_W-1:0] data_wr, data_rd, rd;
	logic [bus_pkg::BE_W-1:0] data_be;
	logic [plat_pkg::LED_W-1:0] pio_leds;

	// the model holds every RAM word that the testbench has filled in full.
	logic [bus_pkg::DATA_W-1:0] model[plat_pkg::RAM_WORDS] = '{default: '0};
	logic filled[plat_pkg::RAM_WORDS] = '{default: 1'b0};
	logic [bus_pkg::OFFSET_W-1:0] written[$];

	int seed = 32'hd113_6973;
	int cycles = 0;
	int n;

	clk_gen clocks (.*);
	platform_top i_dut (.clk_clk(clk), .*);

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation FAILED");
		$fatal(1);
	end

	task automatic compare(input string name, input logic [31:0] want, got);
		if (got !== want) begin
			$display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, want, got);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	task automatic next_cycles(input int count);
		repeat (count) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic access(input string name, input logic [1:0] region, input logic [7:0] off,
			input logic wr_en, input logic [31:0] d, input logic [3:0] bes);
		int latency;
		@(posedge clk);
		#1;
		addr = {region, 20'd0, off}; // the region sits in the top two address bits.
		data_wr = d;
		data_be = bes;
		write = wr_en;
		start = 1'b1;
		latency = 0;
		do begin
			@(posedge clk);
			#1;
			start = 1'b0;
			latency++;
		end while (!ready);
		compare({name, " latency"}, ACCESS_CYCLES, latency);
		rd = data_rd;
	endtask

	task automatic bus_write(input string name, input logic [1:0] region, input logic [7:0] off,
			input logic [31:0] d, input logic [3:0] bes);
		access(name, region, off, 1'b1, d, bes);
	endtask

	task automatic bus_read(input string name, input logic [1:0] region, input logic [7:0] off);
		access(name, region, off, 1'b0, '0, 4'hf);
	endtask

	task automatic reset_and_unmapped();
		compare("reset outputs", 0, 32'({ready, irq, pio_leds, cpu_halt}));
		bus_read("unmapped read", NONE, 8'h5a);
		compare("unmapped read", bus_pkg::UNMAPPED_RD, rd);
		bus_write("ram write", RAM, 8'h5a, 32'h1234_5678, 4'hf);
		bus_write("unmapped write", NONE, 8'h5a, 32'hffff_ffff, 4'hf);
		bus_read("ram after unmapped write", RAM, 8'h5a);
		compare("ram after unmapped write", 32'h1234_5678, rd);
	endtask

	task automatic ram_readback();
		logic [7:0] off;
		logic [3:0] bes;
		logic [31:0] d, mask;
		repeat (32) begin
			off = 8'($random(seed));
			d = $random(seed);
			bes = 4'($random(seed)) | 4'b0001;
			mask = {{8{bes[3]}}, {8{bes[2]}}, {8{bes[1]}}, {8{bes[0]}}};
			if (!filled[off]) begin
				// the inverse goes in first, so disabled bytes must keep it.
				bus_write("ram fill", RAM, off, ~d, 4'hf);
				model[off] = ~d;
				filled[off] = 1'b1;
			end
			bus_write("ram write", RAM, off, d, bes);
			model[off] = (model[off] & ~mask) | (d & mask);
			written.push_back(off);
		end
		foreach (written[i]) begin
			bus_read("ram read", RAM, written[i]);
			compare("ram read", model[written[i]], rd);
		end
	endtask

	task automatic pio_behavior();
		bus_write("pio leds write", PIO, plat_pkg::PIO_LEDS, 32'ha5, 4'hf);
		compare("pio leds pins", 32'ha5, 32'(pio_leds));
		bus_read("pio leds read", PIO, plat_pkg::PIO_LEDS);
		compare("pio leds read", 32'ha5, rd);
		btns = 4'b0010;
		next_cycles(plat_pkg::DEBOUNCE_CYCLES / 2); // too short to be taken.
		btns = '0;
		next_cycles(SETTLE);
		bus_read("pio glitch", PIO, plat_pkg::PIO_EDGE);
		compare("pio glitch edge", 0, rd);
		compare("pio glitch irq", 0, 32'(irq));
		btns = 4'b0100;
		next_cycles(SETTLE);
		bus_read("pio buttons", PIO, plat_pkg::PIO_BTNS);
		compare("pio buttons", 32'h4, rd);
		bus_read("pio edge", PIO, plat_pkg::PIO_EDGE);
		compare("pio edge", 32'h4, rd);
		compare("pio irq set", 1, 32'(irq));
		bus_write("pio edge clear", PIO, plat_pkg::PIO_EDGE, 32'h4, 4'hf);
		bus_read("pio edge cleared", PIO, plat_pkg::PIO_EDGE);
		compare("pio edge cleared", 0, rd);
		compare("pio irq cleared", 0, 32'(irq));
		btns = '0;
	endtask

	task automatic timer_behavior();
		bus_write("timer reload", TMR, plat_pkg::TMR_RELOAD, RELOAD, 4'hf);
		bus_write("timer enable", TMR, plat_pkg::TMR_CTRL, 32'h3, 4'hf);
		for (n = 0; !irq && n <= RELOAD + 2; n++)
			next_cycles(1);
		compare("timer expiry", 1, 32'(irq && n >= RELOAD && n <= RELOAD + 2));
		bus_read("timer status", TMR, plat_pkg::TMR_STATUS);
		compare("timer status", 1, rd);
		bus_write("timer clear", TMR, plat_pkg::TMR_STATUS, 32'h1, 4'hf);
		compare("timer irq cleared", 0, 32'(irq));
		// the counter keeps running but the interrupt stays masked.
		bus_write("timer irq off", TMR, plat_pkg::TMR_CTRL, 32'h1, 4'hf);
		repeat (RELOAD + 3) begin
			next_cycles(1);
			compare("timer irq masked", 0, 32'(irq));
		end
		bus_read("timer masked status", TMR, plat_pkg::TMR_STATUS);
		compare("timer masked status", 1, rd);
		bus_write("timer stop", TMR, plat_pkg::TMR_CTRL, 32'h0, 4'hf);
	endtask

	task automatic halt_behavior();
		repeat (8) begin
			halt = ~halt; // toggles well inside the debounce window.
			repeat (plat_pkg::DEBOUNCE_CYCLES / 4) begin
				next_cycles(1);
				compare("halt bounce", 0, 32'(cpu_halt));
			end
		end
		next_cycles(SETTLE);
		compare("halt after bounce", 0, 32'(cpu_halt));
		halt = 1'b1;
		for (n = 0; !cpu_halt && n <= plat_pkg::DEBOUNCE_CYCLES + 4; n++)
			next_cycles(1);
		compare("halt delay", 1, 32'(cpu_halt && n >= plat_pkg::DEBOUNCE_CYCLES
			&& n <= plat_pkg::DEBOUNCE_CYCLES + 4));
	endtask

	initial begin
		halt = 1'b0;
		btns = '0;
		addr = '0;
		data_wr = '0;
		data_be = '0;
		write = 1'b0;
		start = 1'b0;
		@(negedge rst);
		reset_and_unmapped();
		ram_readback();
		pio_behavior();
		timer_behavior();
		halt_behavior();
		$display("Simulation PASSED");
		$finish;
	end

endmodule
